// File: all.f
src/riscv_bus_pkg.sv
src/riscv_ahb_ifetch.sv
src/riscv_ahb_dmem.sv
src/riscv_ahb_bus_top.sv
tests/riscv_ahb_bus_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the bus layer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f all.f \
  --top-module riscv_ahb_bus_tb \
  -o riscv_ahb_bus_sim

./obj_dir/riscv_ahb_bus_sim | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
  echo "simulation reported failure"
  exit 1
fi

if ! grep -q "PASS: all tests" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi

echo "simulation passed"

// File: src/riscv_ahb_bus_top.sv
//////////////////////////////////////////////////
// Bus interface top, fetch and data bridges on
// the ins and dat AHB-Lite master ports
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module riscv_ahb_bus_top
  import riscv_bus_pkg::*;
(
  input  logic            HCLK,
  input  logic            rst_n,

  // Core fetch port
  input  logic            fetch_req,
  input  fetch_req_t      fetch_in,
  output logic            fetch_ack,
  output fetch_rsp_t      fetch_out,

  // Core data port
  input  logic            dmem_req,
  input  dmem_req_t       dmem_in,
  output logic            dmem_ack,
  output dmem_rsp_t       dmem_out,

  // Instruction AHB-Lite master
  output logic            ins_HSEL,
  output logic [XLEN-1:0] ins_HADDR,
  output logic [XLEN-1:0] ins_HWDATA,
  input  logic [XLEN-1:0] ins_HRDATA,
  output logic            ins_HWRITE,
  output logic [2:0]      ins_HSIZE,
  output logic [2:0]      ins_HBURST,
  output logic [3:0]      ins_HPROT,
  output logic [1:0]      ins_HTRANS,
  output logic            ins_HMASTLOCK,
  input  logic            ins_HREADY,
  input  logic            ins_HRESP,

  // Data AHB-Lite master
  output logic            dat_HSEL,
  output logic [XLEN-1:0] dat_HADDR,
  output logic [XLEN-1:0] dat_HWDATA,
  input  logic [XLEN-1:0] dat_HRDATA,
  output logic            dat_HWRITE,
  output logic [2:0]      dat_HSIZE,
  output logic [2:0]      dat_HBURST,
  output logic [3:0]      dat_HPROT,
  output logic [1:0]      dat_HTRANS,
  output logic            dat_HMASTLOCK,
  input  logic            dat_HREADY,
  input  logic            dat_HRESP
);

  // Fetch never writes
  assign ins_HWDATA = '0;

  //////////////////////////////////////////////////
  // Instruction fetch bridge
  //////////////////////////////////////////////////
  riscv_ahb_ifetch ifetch (
    .HCLK      ( HCLK          ),
    .rst_n     ( rst_n         ),
    .fetch_req ( fetch_req     ),
    .fetch_in  ( fetch_in      ),
    .fetch_ack ( fetch_ack     ),
    .fetch_out ( fetch_out     ),
    .HSEL      ( ins_HSEL      ),
    .HADDR     ( ins_HADDR     ),
    .HWRITE    ( ins_HWRITE    ),
    .HSIZE     ( ins_HSIZE     ),
    .HBURST    ( ins_HBURST    ),
    .HPROT     ( ins_HPROT     ),
    .HTRANS    ( ins_HTRANS    ),
    .HMASTLOCK ( ins_HMASTLOCK ),
    .HRDATA    ( ins_HRDATA    ),
    .HREADY    ( ins_HREADY    ),
    .HRESP     ( ins_HRESP     )
  );

  //////////////////////////////////////////////////
  // Data memory bridge
  //////////////////////////////////////////////////
  riscv_ahb_dmem dmem (
    .HCLK      ( HCLK          ),
    .rst_n     ( rst_n         ),
    .dmem_req  ( dmem_req      ),
    .dmem_in   ( dmem_in       ),
    .dmem_ack  ( dmem_ack      ),
    .dmem_out  ( dmem_out      ),
    .HSEL      ( dat_HSEL      ),
    .HADDR     ( dat_HADDR     ),
    .HWDATA    ( dat_HWDATA    ),
    .HWRITE    ( dat_HWRITE    ),
    .HSIZE     ( dat_HSIZE     ),
    .HBURST    ( dat_HBURST    ),
    .HPROT     ( dat_HPROT     ),
    .HTRANS    ( dat_HTRANS    ),
    .HMASTLOCK ( dat_HMASTLOCK ),
    .HRDATA    ( dat_HRDATA    ),
    .HREADY    ( dat_HREADY    ),
    .HRESP     ( dat_HRESP     )
  );

endmodule

`default_nettype wire

// File: src/riscv_ahb_dmem.sv
//////////////////////////////////////////////////
// Data memory bridge with store lane steering,
// load extension and misalignment check
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module riscv_ahb_dmem
  import riscv_bus_pkg::*;
(
  input  logic            HCLK,
  input  logic            rst_n,

  // Core data port
  input  logic            dmem_req,
  input  dmem_req_t       dmem_in,
  output logic            dmem_ack,
  output dmem_rsp_t       dmem_out,

  // AHB-Lite master
  output logic            HSEL,
  output logic [XLEN-1:0] HADDR,
  output logic [XLEN-1:0] HWDATA,
  output logic            HWRITE,
  output logic [2:0]      HSIZE,
  output logic [2:0]      HBURST,
  output logic [3:0]      HPROT,
  output logic [1:0]      HTRANS,
  output logic            HMASTLOCK,
  input  logic [XLEN-1:0] HRDATA,
  input  logic            HREADY,
  input  logic            HRESP
);

  bus_state_t      state;
  logic            accept;
  logic            start;
  logic            misalign_d;
  logic            data_done;
  logic [2:0]      hsize_d;
  logic [XLEN-1:0] wdata_lanes;

  // Latched transfer attributes
  logic [XLEN-1:0] haddr_q;
  logic [XLEN-1:0] hwdata_q;
  logic [2:0]      hsize_q;
  logic            hwrite_q;
  mem_size_t       size_q;

  // Load path
  logic [7:0]      load_byte;
  logic [15:0]     load_half;
  logic [XLEN-1:0] load_ext;

  // Request taken, whether or not it reaches the bus
  assign accept    = dmem_req && !dmem_ack && (state == ST_IDLE);
  assign start     = accept && !misalign_d;
  assign data_done = (state == ST_DATA) && HREADY;

  //////////////////////////////////////////////////
  // Request decode
  //////////////////////////////////////////////////
  // Natural alignment per access size
  always_comb begin
    case (dmem_in.size)
      MEM_HALF, MEM_UHALF: misalign_d = dmem_in.addr[0];
      MEM_WORD:            misalign_d = |dmem_in.addr[1:0];
      default:             misalign_d = 1'b0;
    endcase
  end

  // HSIZE mapping and store data replicated over all lanes
  always_comb begin
    case (dmem_in.size)
      MEM_BYTE, MEM_UBYTE: begin
        hsize_d     = HSIZE_BYTE;
        wdata_lanes = {(XLEN/8){dmem_in.wdata[7:0]}};
      end
      MEM_HALF, MEM_UHALF: begin
        hsize_d     = HSIZE_HALF;
        wdata_lanes = {(XLEN/16){dmem_in.wdata[15:0]}};
      end
      default: begin
        hsize_d     = HSIZE_WORD;
        wdata_lanes = dmem_in.wdata;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Transfer FSM
  //////////////////////////////////////////////////
  always_ff @(posedge HCLK) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      dmem_ack <= 1'b0;
    end else begin
      dmem_ack <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (start) begin
            state <= ST_ADDR;
          end else if (accept) begin
            // Misaligned, answer next cycle without a transfer
            dmem_ack <= 1'b1;
          end
        end
        ST_ADDR: begin
          state <= ST_DATA;
        end
        // Wait states stretch this state
        ST_DATA: begin
          if (HREADY) begin
            state    <= ST_IDLE;
            dmem_ack <= 1'b1;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Load lane select and extension
  //////////////////////////////////////////////////
  assign load_byte = HRDATA[8*haddr_q[1:0] +: 8];
  assign load_half = HRDATA[16*haddr_q[1] +: 16];

  always_comb begin
    case (size_q)
      MEM_BYTE:  load_ext = {{(XLEN-8){load_byte[7]}}, load_byte};
      MEM_HALF:  load_ext = {{(XLEN-16){load_half[15]}}, load_half};
      MEM_UBYTE: load_ext = {{(XLEN-8){1'b0}}, load_byte};
      MEM_UHALF: load_ext = {{(XLEN-16){1'b0}}, load_half};
      default:   load_ext = HRDATA;
    endcase
  end

  //////////////////////////////////////////////////
  // Transfer latch and response registers
  //////////////////////////////////////////////////
  always_ff @(posedge HCLK) begin
    if (start) begin
      haddr_q  <= dmem_in.addr;
      hsize_q  <= hsize_d;
      hwrite_q <= dmem_in.we;
      hwdata_q <= wdata_lanes;
      size_q   <= dmem_in.size;
    end

    if (accept && misalign_d) begin
      dmem_out.rdata      <= '0;
      dmem_out.misaligned <= 1'b1;
      dmem_out.error      <= 1'b0;
    end else if (data_done) begin
      // Stores return zero
      dmem_out.rdata      <= hwrite_q ? '0 : load_ext;
      dmem_out.misaligned <= 1'b0;
      dmem_out.error      <= HRESP;
    end
  end

  // Bus outputs
  assign HSEL      = (state == ST_ADDR);
  assign HTRANS    = (state == ST_ADDR) ? HTRANS_NONSEQ : HTRANS_IDLE;
  assign HADDR     = haddr_q;
  assign HWRITE    = hwrite_q;
  assign HSIZE     = hsize_q;
  // Held from accept through the data phase
  assign HWDATA    = hwdata_q;
  assign HBURST    = HBURST_SINGLE;
  assign HPROT     = HPROT_DATA;
  assign HMASTLOCK = 1'b0;

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////
  // Address phase size and address agree
  assert property (@(posedge HCLK) disable iff (!rst_n)
    (HTRANS == HTRANS_NONSEQ) |->
      ((HSIZE != HSIZE_HALF) || !HADDR[0]) &&
      ((HSIZE != HSIZE_WORD) || (HADDR[1:0] == 2'b00)));

  // Misaligned request answered with no address phase
  assert property (@(posedge HCLK) disable iff (!rst_n)
    (accept && misalign_d) |=>
      (HTRANS == HTRANS_IDLE) && dmem_ack && dmem_out.misaligned);

endmodule

`default_nettype wire

// File: src/riscv_ahb_ifetch.sv
//////////////////////////////////////////////////
// Instruction fetch bridge, core fetch requests
// to single-word AHB-Lite reads
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module riscv_ahb_ifetch
  import riscv_bus_pkg::*;
(
  input  logic            HCLK,
  input  logic            rst_n,

  // Core fetch port
  input  logic            fetch_req,
  input  fetch_req_t      fetch_in,
  output logic            fetch_ack,
  output fetch_rsp_t      fetch_out,

  // AHB-Lite master, read only
  output logic            HSEL,
  output logic [XLEN-1:0] HADDR,
  output logic            HWRITE,
  output logic [2:0]      HSIZE,
  output logic [2:0]      HBURST,
  output logic [3:0]      HPROT,
  output logic [1:0]      HTRANS,
  output logic            HMASTLOCK,
  input  logic [XLEN-1:0] HRDATA,
  input  logic            HREADY,
  input  logic            HRESP
);

  bus_state_t      state;
  logic            start;
  logic            data_done;
  logic [XLEN-1:0] haddr_q;

  // Ignore req in the ack cycle, the requester may still hold it
  assign start     = fetch_req && !fetch_ack && (state == ST_IDLE);
  // Data phase closes on the first edge with HREADY high
  assign data_done = (state == ST_DATA) && HREADY;

  //////////////////////////////////////////////////
  // Transfer FSM
  //////////////////////////////////////////////////
  always_ff @(posedge HCLK) begin
    if (!rst_n) begin
      state     <= ST_IDLE;
      fetch_ack <= 1'b0;
    end else begin
      // Ack is a single-cycle pulse
      fetch_ack <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (start) begin
            state <= ST_ADDR;
          end
        end
        // One address phase cycle, sole master so no wait here
        ST_ADDR: begin
          state <= ST_DATA;
        end
        ST_DATA: begin
          if (HREADY) begin
            state     <= ST_IDLE;
            fetch_ack <= 1'b1;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Address latch and response registers
  //////////////////////////////////////////////////
  always_ff @(posedge HCLK) begin
    // Fetch always word aligned
    if (start) begin
      haddr_q <= {fetch_in.addr[XLEN-1:2], 2'b00};
    end
    // Parcel, its address and the slave response
    if (data_done) begin
      fetch_out.parcel    <= HRDATA;
      fetch_out.parcel_pc <= haddr_q;
      fetch_out.error     <= HRESP;
    end
  end

  // Address phase decoded straight from state
  assign HSEL      = (state == ST_ADDR);
  assign HTRANS    = (state == ST_ADDR) ? HTRANS_NONSEQ : HTRANS_IDLE;
  assign HADDR     = haddr_q;
  assign HWRITE    = 1'b0;
  assign HSIZE     = HSIZE_WORD;
  assign HBURST    = HBURST_SINGLE;
  assign HPROT     = HPROT_INSTR;
  assign HMASTLOCK = 1'b0;

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////
  // A stalled data phase holds its address, with no new transfer and no ack
  assert property (@(posedge HCLK) disable iff (!rst_n)
    (state == ST_DATA && !HREADY) |=>
      (HTRANS != HTRANS_NONSEQ) && !fetch_ack && $stable(HADDR));

  // Ack never lasts past one cycle
  assert property (@(posedge HCLK) disable iff (!rst_n)
    fetch_ack |=> !fetch_ack);

endmodule

`default_nettype wire

// File: src/riscv_bus_pkg.sv
//////////////////////////////////////////////////
// Bus widths, AHB-Lite encodings and the core-side
// request and response structs of both bridges
//////////////////////////////////////////////////

`default_nettype none

package riscv_bus_pkg;

  //////////////////////////////////////////////////
  // Widths and reset vector
  //////////////////////////////////////////////////
  localparam int XLEN = 32;
  // First fetch address after reset
  localparam logic [XLEN-1:0] PC_INIT = 32'h0000_0200;

  //////////////////////////////////////////////////
  // AHB-Lite encodings
  //////////////////////////////////////////////////
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

  localparam logic [2:0] HSIZE_BYTE = 3'b000;
  localparam logic [2:0] HSIZE_HALF = 3'b001;
  localparam logic [2:0] HSIZE_WORD = 3'b010;

  // Single transfers only
  localparam logic [2:0] HBURST_SINGLE = 3'b000;

  // Bit 0 set for data, bit 1 set for privileged
  localparam logic [3:0] HPROT_INSTR = 4'b0010;
  localparam logic [3:0] HPROT_DATA  = 4'b0011;

  // Access size, funct3 encoding of loads and stores
  typedef enum logic [2:0] {
    MEM_BYTE  = 3'b000,
    MEM_HALF  = 3'b001,
    MEM_WORD  = 3'b010,
    MEM_UBYTE = 3'b100,
    MEM_UHALF = 3'b101
  } mem_size_t;

  // Bridge transfer FSM, common to fetch and data side
  typedef enum logic [1:0] {
    ST_IDLE = 2'b00,
    ST_ADDR = 2'b01,
    ST_DATA = 2'b10
  } bus_state_t;

  //////////////////////////////////////////////////
  // Core-side request and response structs
  //////////////////////////////////////////////////
  typedef struct packed {
    logic [XLEN-1:0] addr;
  } fetch_req_t;

  typedef struct packed {
    logic [XLEN-1:0] parcel;
    logic [XLEN-1:0] parcel_pc;
    logic            error;
  } fetch_rsp_t;

  typedef struct packed {
    logic            we;
    mem_size_t       size;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
  } dmem_req_t;

  typedef struct packed {
    logic [XLEN-1:0] rdata;
    logic            misaligned;
    logic            error;
  } dmem_rsp_t;

endpackage

`default_nettype wire

// File: tests/bus_golden.txt
// test port we size addr wdata slave_word waits hresp exp_data exp_mis exp_err
// port 0 is ins, 1 is dat; size in funct3 encoding; last line port ff ends the list
// Fetch, no wait states
1 0 0 2 00000200 00000000 00000013 0 0 00000013 0 0
1 0 0 2 00000206 00000000 12345678 0 0 12345678 0 0
// Store lanes
2 1 1 0 00001003 000000a5 00000000 0 0 00000000 0 0
2 1 1 1 00001002 0000beef 00000000 0 0 00000000 0 0
2 1 1 2 00001000 cafef00d 00000000 0 0 00000000 0 0
// Load extension
3 1 0 0 00001000 00000000 8091a2f3 0 0 fffffff3 0 0
3 1 0 0 00001001 00000000 8091a2f3 0 0 ffffffa2 0 0
3 1 0 0 00001002 00000000 8091a2f3 0 0 ffffff91 0 0
3 1 0 4 00001002 00000000 8091a2f3 0 0 00000091 0 0
3 1 0 4 00001003 00000000 8091a2f3 0 0 00000080 0 0
3 1 0 1 00001000 00000000 8091a2f3 0 0 ffffa2f3 0 0
3 1 0 1 00001002 00000000 8091a2f3 0 0 ffff8091 0 0
3 1 0 5 00001000 00000000 8091a2f3 0 0 0000a2f3 0 0
3 1 0 5 00001002 00000000 8091a2f3 0 0 00008091 0 0
3 1 0 2 00001000 00000000 8091a2f3 0 0 8091a2f3 0 0
3 1 0 0 00001001 00000000 12345f78 0 0 0000005f 0 0
// Misaligned
4 1 0 1 00001001 00000000 00000000 0 0 00000000 1 0
4 1 0 2 00001002 00000000 00000000 0 0 00000000 1 0
4 1 0 2 00001001 00000000 00000000 0 0 00000000 1 0
4 1 0 5 00001003 00000000 00000000 0 0 00000000 1 0
4 1 1 1 00001001 00001234 00000000 0 0 00000000 1 0
// Wait states and errors, both ports at once
5 0 0 2 00000300 00000000 00100073 1 0 00100073 0 0
5 1 0 2 00002000 00000000 13572468 2 0 13572468 0 0
5 0 0 2 00000304 00000000 deadbeef 3 1 00000000 0 1
5 1 0 2 00002004 00000000 deadbeef 3 1 00000000 0 1
5 1 1 0 00002008 0000005a 00000000 1 0 00000000 0 0
5 1 0 4 0000200b 00000000 7e000000 1 0 0000007e 0 0
5 0 0 2 00000308 00000000 00000093 2 0 00000093 0 0
ff ff ff ff ffffffff ffffffff ffffffff ff ff ffffffff ff ff

// File: tests/riscv_ahb_bus_tb.sv
//////////////////////////////////////////////////
// Testbench for the AHB-Lite bus layer with two
// slave models and a golden-file access driver
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

// Behavioral AHB-Lite slave, records the last transfer it saw
module ahb_slave_model
  import riscv_bus_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic [1:0]      htrans,
  input  logic [XLEN-1:0] haddr,
  input  logic [2:0]      hsize,
  input  logic            hwrite,
  input  logic [3:0]      hprot,
  input  logic [XLEN-1:0] hwdata,
  input  logic [XLEN-1:0] cfg_rdata,
  input  logic [3:0]      cfg_waits,
  input  logic            cfg_resp,
  output logic            hready,
  output logic [XLEN-1:0] hrdata,
  output logic            hresp,
  output logic [XLEN-1:0] seen_addr,
  output logic [XLEN-1:0] seen_wdata,
  output logic [2:0]      seen_size,
  output logic            seen_write,
  output logic [3:0]      seen_prot,
  output logic [31:0]     xfer_count
);

  logic       pending;
  logic [3:0] cnt;

  initial begin
    hready     = 1'b1;
    hresp      = 1'b0;
    hrdata     = '0;
    pending    = 1'b0;
    cnt        = '0;
    xfer_count = '0;
  end

  // Outputs change on the falling edge, DUT samples on the rising one
  always @(negedge clk) begin
    if (!rst_n) begin
      hready     <= 1'b1;
      hresp      <= 1'b0;
      pending    <= 1'b0;
      xfer_count <= '0;
    end else begin
      hrdata <= cfg_rdata;
      if (pending) begin
        seen_wdata <= hwdata;
        if (cnt == 4'd0) begin
          // Next rising edge completes the data phase
          hready  <= 1'b1;
          hresp   <= cfg_resp;
          pending <= 1'b0;
        end else begin
          hready <= 1'b0;
          hresp  <= 1'b0;
          cnt    <= cnt - 4'd1;
        end
      end else begin
        hready <= 1'b1;
        hresp  <= 1'b0;
      end
      // Address phase, data phase starts next cycle
      if (htrans == HTRANS_NONSEQ) begin
        seen_addr  <= haddr;
        seen_size  <= hsize;
        seen_write <= hwrite;
        seen_prot  <= hprot;
        pending    <= 1'b1;
        cnt        <= cfg_waits;
        xfer_count <= xfer_count + 32'd1;
      end
    end
  end

endmodule

module riscv_ahb_bus_tb
  import riscv_bus_pkg::*;
;

  localparam int NF   = 12;
  localparam int MAXL = 64;

  logic HCLK;
  logic rst_n;
  logic fetch_req;
  logic fetch_ack;
  logic dmem_req;
  logic dmem_ack;
  fetch_req_t fetch_in;
  fetch_rsp_t fetch_out;
  dmem_req_t  dmem_in;
  dmem_rsp_t  dmem_out;

  // Instruction port
  logic            ins_HSEL, ins_HWRITE, ins_HMASTLOCK, ins_HREADY, ins_HRESP;
  logic [XLEN-1:0] ins_HADDR, ins_HWDATA, ins_HRDATA;
  logic [2:0]      ins_HSIZE, ins_HBURST;
  logic [3:0]      ins_HPROT;
  logic [1:0]      ins_HTRANS;
  // Data port
  logic            dat_HSEL, dat_HWRITE, dat_HMASTLOCK, dat_HREADY, dat_HRESP;
  logic [XLEN-1:0] dat_HADDR, dat_HWDATA, dat_HRDATA;
  logic [2:0]      dat_HSIZE, dat_HBURST;
  logic [3:0]      dat_HPROT;
  logic [1:0]      dat_HTRANS;

  // Slave setup and what the slaves observed
  logic [XLEN-1:0] ins_cfg_rdata, dat_cfg_rdata;
  logic [3:0]      ins_cfg_waits, dat_cfg_waits;
  logic            ins_cfg_resp, dat_cfg_resp;
  logic [XLEN-1:0] ins_seen_addr, ins_seen_wdata, dat_seen_addr, dat_seen_wdata;
  logic [2:0]      ins_seen_size, dat_seen_size;
  logic            ins_seen_write, dat_seen_write;
  logic [3:0]      ins_seen_prot, dat_seen_prot;
  logic [31:0]     ins_xfers, dat_xfers;

  logic [31:0] golden_mem [0:NF*MAXL-1];
  logic [31:0] lfsr_state;
  logic        first_fetch_seen;
  int          errors;
  int          checks;
  int          cycles;
  int          cycle_limit;

  riscv_ahb_bus_top riscv_ahb_bus_top_inst (.*);

  ahb_slave_model ins_slave (
    .clk(HCLK), .rst_n(rst_n), .htrans(ins_HTRANS), .haddr(ins_HADDR),
    .hsize(ins_HSIZE), .hwrite(ins_HWRITE), .hprot(ins_HPROT), .hwdata(ins_HWDATA),
    .cfg_rdata(ins_cfg_rdata), .cfg_waits(ins_cfg_waits), .cfg_resp(ins_cfg_resp),
    .hready(ins_HREADY), .hrdata(ins_HRDATA), .hresp(ins_HRESP),
    .seen_addr(ins_seen_addr), .seen_wdata(ins_seen_wdata), .seen_size(ins_seen_size),
    .seen_write(ins_seen_write), .seen_prot(ins_seen_prot), .xfer_count(ins_xfers)
  );

  ahb_slave_model dat_slave (
    .clk(HCLK), .rst_n(rst_n), .htrans(dat_HTRANS), .haddr(dat_HADDR),
    .hsize(dat_HSIZE), .hwrite(dat_HWRITE), .hprot(dat_HPROT), .hwdata(dat_HWDATA),
    .cfg_rdata(dat_cfg_rdata), .cfg_waits(dat_cfg_waits), .cfg_resp(dat_cfg_resp),
    .hready(dat_HREADY), .hrdata(dat_HRDATA), .hresp(dat_HRESP),
    .seen_addr(dat_seen_addr), .seen_wdata(dat_seen_wdata), .seen_size(dat_seen_size),
    .seen_write(dat_seen_write), .seen_prot(dat_seen_prot), .xfer_count(dat_xfers)
  );

  //////////////////////////////////////////////////
  // Clock, timeout and helpers
  //////////////////////////////////////////////////
  always #20 HCLK = ~HCLK;

  always @(posedge HCLK) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: no acknowledge after %0d cycles", cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  function automatic logic [31:0] field(input int line, input int col);
    return golden_mem[line*NF + col];
  endfunction

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Address phase of a single, unlocked transfer with its select
  task automatic verify_addr_phase(input string port, input logic sel,
                                   input logic [2:0] burst, input logic lock);
    check_value({port, "_HSEL"}, {31'd0, sel}, 32'd1);
    check_value({port, "_HBURST"}, {29'd0, burst}, {29'd0, HBURST_SINGLE});
    check_value({port, "_HMASTLOCK"}, {31'd0, lock}, 32'd0);
  endtask

  // Wait one cycle after ack plus 0 to 3 random idle cycles
  task automatic idle_gap();
    int n;
    n = 1 + {30'd0, lfsr_bit(), lfsr_bit()};
    repeat (n) @(negedge HCLK);
  endtask

  //////////////////////////////////////////////////
  // Per-port access drivers
  //////////////////////////////////////////////////
  task automatic run_fetch(input int ln);
    logic [31:0] addr;
    logic [31:0] xfers_before;
    int          lat;
    addr = field(ln, 4);
    idle_gap();
    ins_cfg_rdata = field(ln, 6);
    ins_cfg_waits = 4'(field(ln, 7));
    ins_cfg_resp  = 1'(field(ln, 8));
    fetch_in.addr = addr;
    xfers_before  = ins_xfers;
    fetch_req     = 1'b1;
    lat = 0;
    do begin
      @(negedge HCLK);
      lat++;
      if (ins_HTRANS == HTRANS_NONSEQ) begin
        verify_addr_phase("ins", ins_HSEL, ins_HBURST, ins_HMASTLOCK);
      end
    end while (!fetch_ack);
    fetch_req = 1'b0;
    check_value("fetch latency", lat, 3 + field(ln, 7));
    check_value("ins transfer count", ins_xfers, xfers_before + 32'd1);
    // First fetch comes from the reset vector
    if (!first_fetch_seen) begin
      check_value("first fetch address", ins_seen_addr, PC_INIT);
    end
    first_fetch_seen = 1'b1;
    check_value("ins_HADDR", ins_seen_addr, {addr[31:2], 2'b00});
    check_value("ins_HSIZE", {29'd0, ins_seen_size}, {29'd0, HSIZE_WORD});
    check_value("ins_HPROT", {28'd0, ins_seen_prot}, {28'd0, HPROT_INSTR});
    check_value("ins_HWRITE", {31'd0, ins_seen_write}, 32'd0);
    check_value("ins_HWDATA", ins_seen_wdata, 32'd0);
    check_value("fetch_out.parcel_pc", fetch_out.parcel_pc, {addr[31:2], 2'b00});
    check_value("fetch_out.error", {31'd0, fetch_out.error}, field(ln, 11));
    if (field(ln, 11) == 32'd0) begin
      check_value("fetch_out.parcel", fetch_out.parcel, field(ln, 9));
    end
  endtask

  task automatic run_dmem(input int ln);
    logic [31:0] addr;
    logic [31:0] wd;
    logic [31:0] lanes;
    logic [2:0]  sz;
    logic [31:0] xfers_before;
    logic        mis;
    int          lat;
    addr = field(ln, 4);
    wd   = field(ln, 5);
    sz   = 3'(field(ln, 3));
    mis  = 1'(field(ln, 10));
    idle_gap();
    dat_cfg_rdata = field(ln, 6);
    dat_cfg_waits = 4'(field(ln, 7));
    dat_cfg_resp  = 1'(field(ln, 8));
    dmem_in.we    = 1'(field(ln, 2));
    dmem_in.size  = mem_size_t'(sz);
    dmem_in.addr  = addr;
    dmem_in.wdata = wd;
    xfers_before  = dat_xfers;
    dmem_req      = 1'b1;
    lat = 0;
    do begin
      @(negedge HCLK);
      lat++;
      if (dat_HTRANS == HTRANS_NONSEQ) begin
        verify_addr_phase("dat", dat_HSEL, dat_HBURST, dat_HMASTLOCK);
      end
    end while (!dmem_ack);
    dmem_req = 1'b0;
    check_value("dmem_out.misaligned", {31'd0, dmem_out.misaligned}, {31'd0, mis});
    check_value("dmem_out.error", {31'd0, dmem_out.error}, field(ln, 11));
    if (mis) begin
      check_value("dmem latency", lat, 1);
      // Slave counts on the falling edge, so any address phase is in by now
      @(posedge HCLK);
      check_value("dat transfer count", dat_xfers, xfers_before);
    end else begin
      check_value("dmem latency", lat, 3 + field(ln, 7));
      check_value("dat_HADDR", dat_seen_addr, addr);
      check_value("dat_HSIZE", {29'd0, dat_seen_size}, {30'd0, sz[1:0]});
      check_value("dat_HWRITE", {31'd0, dat_seen_write}, field(ln, 2));
      check_value("dat_HPROT", {28'd0, dat_seen_prot}, {28'd0, HPROT_DATA});
      if (field(ln, 2) != 32'd0) begin
        // Byte and halfword stores repeat on every lane
        case (sz[1:0])
          2'b00:   lanes = {4{wd[7:0]}};
          2'b01:   lanes = {2{wd[15:0]}};
          default: lanes = wd;
        endcase
        check_value("dat_HWDATA", dat_seen_wdata, lanes);
      end else if (field(ln, 11) == 32'd0) begin
        check_value("dmem_out.rdata", dmem_out.rdata, field(ln, 9));
      end
    end
  endtask

  // Ins and dat lines of one test run side by side
  task automatic run_group(input int first, input int last);
    fork
      begin
        for (int i = first; i <= last; i++) begin
          if (field(i, 1) == 32'd0) run_fetch(i);
        end
      end
      begin
        for (int i = first; i <= last; i++) begin
          if (field(i, 1) == 32'd1) run_dmem(i);
        end
      end
    join
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial begin
    int nlines;
    int first;
    int last;
    int tests;
    int failed;
    int err_before;
    HCLK             = 1'b0;
    rst_n            = 1'b0;
    fetch_req        = 1'b0;
    dmem_req         = 1'b0;
    fetch_in         = '0;
    dmem_in          = '0;
    ins_cfg_rdata    = '0;
    ins_cfg_waits    = '0;
    ins_cfg_resp     = 1'b0;
    dat_cfg_rdata    = '0;
    dat_cfg_waits    = '0;
    dat_cfg_resp     = 1'b0;
    lfsr_state       = 32'ha77afeb8;
    first_fetch_seen = 1'b0;
    errors           = 0;
    checks           = 0;
    cycles           = 0;
    tests            = 0;
    failed           = 0;
    $readmemh("tests/bus_golden.txt", golden_mem);
    // End marker has port ff
    nlines = 0;
    while (field(nlines, 1) != 32'hff) nlines++;
    cycle_limit = nlines * 16 + 200;

    repeat (16) @(negedge HCLK);
    rst_n = 1'b1;
    @(negedge HCLK);
    check_value("ins_HTRANS", {30'd0, ins_HTRANS}, {30'd0, HTRANS_IDLE});
    check_value("dat_HTRANS", {30'd0, dat_HTRANS}, {30'd0, HTRANS_IDLE});
    check_value("ins_HSEL", {31'd0, ins_HSEL}, 32'd0);
    check_value("dat_HSEL", {31'd0, dat_HSEL}, 32'd0);
    check_value("acks", {30'd0, fetch_ack, dmem_ack}, 32'd0);

    first = 0;
    while (first < nlines) begin
      last = first;
      while (last + 1 < nlines && field(last + 1, 0) == field(first, 0)) last++;
      err_before = errors;
      run_group(first, last);
      tests++;
      if (errors != err_before) failed++;
      $display("test %0d: %s, %0d accesses", field(first, 0),
               (errors == err_before) ? "ok" : "failed", last - first + 1);
      first = last + 1;
    end

    $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire
